// ==== compile.f ====
+incdir+include
rtl/barrelPkg.sv
rtl/aluUnit.sv
rtl/threadFetch.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/barrelCore.sv
test/tbBarrelCore.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the barrel core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tbBarrelCore -o simTb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

// ==== include/tbCoreChecks.svh ====
////////////////////////////////////////////////////////////
// Compare tasks, bounded waits and RV32 encoders for the testbench
// Included inside the testbench module, after barrelPkg import
////////////////////////////////////////////////////////////
`ifndef TB_CORE_CHECKS_SVH
`define TB_CORE_CHECKS_SVH

//////////////////////////////////////////////////////////////
// Compare tasks

task automatic checkWord(string name, word_t got, word_t exp);
    if (got !== exp) begin
        $display("error: %s got %h expected %h", name, got, exp);
        failNow("word mismatch");
    end
endtask

task automatic checkByteEn(string name, byteEn_t got, byteEn_t exp);
    if (got !== exp) begin
        $display("error: %s got %h expected %h", name, got, exp);
        failNow("byte enable mismatch");
    end
endtask

task automatic checkStrobes(logic gotRd, logic gotWr, logic expRd, logic expWr);
    if ({gotRd, gotWr} !== {expRd, expWr}) begin
        $display("error: Dmem.rd/Dmem.wr got %h expected %h", {gotRd, gotWr}, {expRd, expWr});
        failNow("strobe mismatch");
    end
endtask

//////////////////////////////////////////////////////////////
// Bounded waits

task automatic waitStores(int count);
    int n;
    n = 0;
    while (gotQ.size() < count) begin
        @(posedge QClk);
        n++;
        if (n > 500) failNow("timed out waiting for data memory stores");
    end
endtask

task automatic waitTrace(int count);
    int n;
    n = 0;
    while (trace0.size() < count) begin
        @(posedge QClk);
        n++;
        if (n > 500) failNow("timed out waiting for thread 0 fetches");
    end
endtask

//////////////////////////////////////////////////////////////
// Instruction encoders

function automatic instr_t encR(int f7, int rs2, int rs1, int f3, int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_OP};
endfunction

function automatic instr_t encI(int imm, int rs1, int f3, int rd, opcode_t op);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
endfunction

function automatic instr_t encS(int imm, int rs2, int rs1, int f3);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], OP_STORE};
endfunction

function automatic instr_t encB(int imm, int rs2, int rs1, int f3);
    logic [12:0] v;
    v = 13'(imm);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], OP_BRANCH};
endfunction

function automatic instr_t encU(word_t imm20, int rd, opcode_t op);
    return {imm20[19:0], 5'(rd), op};
endfunction

function automatic instr_t encJ(int imm, int rd);
    logic [20:0] v;
    v = 21'(imm);
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
endfunction

`endif

// ==== test/tbBarrelCore.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// Directed tests for the barrel core, all four threads at once
// Thread of a fetch is inferred from the fixed ring order
// Stops at the first mismatch
////////////////////////////////////////////////////////////
module tbBarrelCore;
    import barrelPkg::*;

    localparam instr_t NOP  = 32'h0000_0013;   // addi x0,x0,0
    localparam instr_t SPIN = 32'h0000_006f;   // jal x0,0

    typedef struct packed {
        logic [1:0] thr;
        word_t      addr;
        word_t      data;
        byteEn_t    be;
    } storeRec_t;

    logic     QClk;
    logic     reset;
    word_t    PcQ100H;
    instr_t   InstFetchQ101H;
    dmemReq_t Dmem;
    word_t    MemRdDataQ104H;

    instr_t    prog [NUM_THREADS][64];   // Per-thread program, word indexed
    word_t     dmem [word_t];            // Sparse data memory
    storeRec_t gotQ[$];
    storeRec_t expQ[$];
    word_t     trace0[$];                // Thread 0 fetch PCs
    word_t     firstPc [NUM_THREADS];
    int        fetchCnt [NUM_THREADS];
    int        cyc;
    logic      quietCheck;
    instr_t    nextInstr;
    word_t     nextLoad;

    barrelCore i_dut (
        .QClk           (QClk),
        .reset          (reset),
        .PcQ100H        (PcQ100H),
        .InstFetchQ101H (InstFetchQ101H),
        .Dmem           (Dmem),
        .MemRdDataQ104H (MemRdDataQ104H)
    );

    always #20 QClk = ~QClk;

    task automatic failNow(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tbCoreChecks.svh"

    // Fill depends on every address bit
    function automatic word_t memRead(word_t a);
        if (dmem.exists(a)) return dmem[a];
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    //////////////////////////////////////////////////////////////
    // Memory models, sampled mid-cycle

    always @(negedge QClk) begin
        if (reset) begin
            cyc = 0;
            nextInstr = NOP;
            checkStrobes(Dmem.rd, Dmem.wr, 1'b0, 1'b0);   // Quiet in reset
        end else begin
            if (cyc % 4 == 0) trace0.push_back(PcQ100H);
            if (fetchCnt[cyc % 4] == 0) firstPc[cyc % 4] = PcQ100H;
            fetchCnt[cyc % 4]++;
            nextInstr = (PcQ100H < 256) ? prog[cyc % 4][PcQ100H[7:2]] : NOP;
            if (Dmem.wr) begin
                // Q103 holds the fetch from three cycles back
                gotQ.push_back('{thr: 2'((cyc + 1) % 4), addr: Dmem.address,
                                 data: Dmem.writeData, be: Dmem.byteEn});
                dmem[Dmem.address] = Dmem.writeData;
            end else if (quietCheck) begin
                checkStrobes(Dmem.rd, Dmem.wr, 1'b0, 1'b0);
            end
            if (Dmem.rd) nextLoad = memRead(Dmem.address);
            cyc++;
        end
    end

    // Imem and dmem both answer one cycle later
    always @(posedge QClk) begin
        #1;
        InstFetchQ101H = nextInstr;
        MemRdDataQ104H = nextLoad;
    end

    //////////////////////////////////////////////////////////////
    // Test helpers

    task automatic startTest();
        @(posedge QClk);
        #1 reset = 1'b1;
        foreach (prog[t, i]) prog[t][i] = NOP;
        dmem.delete();
        gotQ.delete();
        expQ.delete();
        trace0.delete();
        foreach (fetchCnt[t]) fetchCnt[t] = 0;
        repeat (4) @(posedge QClk);
        #1 reset = 1'b0;
    endtask

    task automatic expectStore(int t, word_t a, word_t d, byteEn_t be);
        expQ.push_back('{thr: 2'(t), addr: a, data: d, be: be});
    endtask

    // Per-thread order must match, threads interleave freely
    task automatic compareStores();
        int gi;
        waitStores(expQ.size());
        for (int t = 0; t < NUM_THREADS; t++) begin
            gi = 0;
            foreach (expQ[e]) begin
                if (expQ[e].thr == t) begin
                    while (gi < gotQ.size() && gotQ[gi].thr != t) gi++;
                    if (gi >= gotQ.size()) failNow("a thread is missing a store");
                    checkWord("Dmem.address", gotQ[gi].addr, expQ[e].addr);
                    checkWord("Dmem.writeData", gotQ[gi].data, expQ[e].data);
                    checkByteEn("Dmem.byteEn", gotQ[gi].be, expQ[e].be);
                    gi++;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Tests

    task automatic testResetOrder();
        startTest();
        quietCheck = 1'b1;                             // No strobe before the store
        for (int t = 0; t < NUM_THREADS; t++) begin
            prog[t][4] = encS(12'h600 + 4 * t, 0, 0, 2);
            prog[t][5] = SPIN;
            expectStore(t, 32'h600 + 4 * t, '0, 4'b1111);
        end
        compareStores();
        quietCheck = 1'b0;
        for (int t = 0; t < NUM_THREADS; t++) checkWord("PcQ100H first", firstPc[t], '0);
    endtask

    task automatic testAlu();
        int f7s [10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};   // add sub xor or and sll srl sra
        int f3s [10] = '{0, 0, 4, 6, 7, 1, 5, 5, 2, 3};     // slt sltu
        word_t a;
        word_t b;
        logic [11:0] immLo;
        word_t immW;
        word_t res [11];
        startTest();
        for (int t = 0; t < NUM_THREADS; t++) begin
            a = $urandom;
            b = $urandom;
            immLo = 12'($urandom);
            immW = {{20{immLo[11]}}, immLo};           // Sign-extended I immediate
            dmem[32'h100 + 16 * t] = a;
            dmem[32'h104 + 16 * t] = b;
            prog[t][0] = encI(12'h100 + 16 * t, 0, 2, 1, OP_LOAD);
            prog[t][1] = encI(12'h104 + 16 * t, 0, 2, 2, OP_LOAD);
            prog[t][2] = encI(int'(immW), 1, 0, 3, OP_OPIMM);
            for (int i = 0; i < 10; i++) prog[t][3 + i] = encR(f7s[i], 2, 1, f3s[i], 4 + i);
            res = '{a + immW, a + b, a - b, a ^ b, a | b, a & b, a << b[4:0], a >> b[4:0],
                    word_t'($signed(a) >>> b[4:0]), word_t'($signed(a) < $signed(b)),
                    word_t'(a < b)};
            for (int i = 0; i < 11; i++) begin
                prog[t][13 + i] = encS(12'h400 + 64 * t + 4 * i, 3 + i, 0, 2);
                expectStore(t, 32'h400 + 64 * t + 4 * i, res[i], 4'b1111);
            end
            prog[t][24] = SPIN;
        end
        compareStores();
    endtask

    task automatic testIsolation();
        word_t v;
        startTest();
        for (int t = 0; t < NUM_THREADS; t++) begin
            v = $urandom;
            dmem[32'h200 + 4 * t] = v;
            prog[t][0] = encI(12'h200 + 4 * t, 0, 2, 5, OP_LOAD);   // Same x5 everywhere
            prog[t][1] = NOP;                                       // All threads load first
            prog[t][2] = encS(12'h680 + 4 * t, 5, 0, 2);
            prog[t][3] = SPIN;
            expectStore(t, 32'h680 + 4 * t, v, 4'b1111);
        end
        compareStores();
    endtask

    task automatic testControl();
        int    bf3 [6] = '{0, 1, 4, 5, 6, 7};   // beq bne blt bge bltu bgeu
        word_t a = 32'hffff_ffff;              // -1 signed, max unsigned
        word_t b = 32'd1;
        logic  taken [6];
        word_t mask = '0;
        word_t expTrace[$];
        taken = '{a == b, a != b, $signed(a) < $signed(b), $signed(a) >= $signed(b),
                  a < b, a >= b};
        startTest();
        expTrace = '{32'd0, 32'd4};
        for (int i = 0; i < 6; i++) begin
            expTrace.push_back(8 + 8 * i);
            if (!taken[i]) begin
                expTrace.push_back(12 + 8 * i);
                mask |= word_t'(1 << i);       // Fall-through adds its bit
            end
        end
        expTrace = {expTrace, 32'd56, 32'd64, 32'd76, 32'd80, 32'd84, 32'd88, 32'd88};
        for (int t = 0; t < NUM_THREADS; t++) begin
            prog[t][0] = encI(-1, 0, 0, 1, OP_OPIMM);
            prog[t][1] = encI(1, 0, 0, 2, OP_OPIMM);
            for (int i = 0; i < 6; i++) begin
                prog[t][2 + 2 * i] = encB(8, 2, 1, bf3[i]);
                prog[t][3 + 2 * i] = encI(1 << i, 3, 0, 3, OP_OPIMM);
            end
            prog[t][14] = encJ(8, 4);                  // Link 60, to 64
            prog[t][15] = encI(64, 3, 0, 3, OP_OPIMM);
            prog[t][16] = encI(76, 0, 0, 5, OP_JALR);  // Link 68, to 76
            prog[t][17] = encI(128, 3, 0, 3, OP_OPIMM);
            prog[t][18] = encI(256, 3, 0, 3, OP_OPIMM);
            prog[t][19] = encS(12'h700 + 16 * t, 3, 0, 2);
            prog[t][20] = encS(12'h704 + 16 * t, 4, 0, 2);
            prog[t][21] = encS(12'h708 + 16 * t, 5, 0, 2);
            prog[t][22] = SPIN;
            expectStore(t, 32'h700 + 16 * t, mask, 4'b1111);
            expectStore(t, 32'h704 + 16 * t, 32'd60, 4'b1111);
            expectStore(t, 32'h708 + 16 * t, 32'd68, 4'b1111);
        end
        compareStores();
        waitTrace(expTrace.size());
        foreach (expTrace[i]) checkWord("PcQ100H thread 0", trace0[i], expTrace[i]);
    endtask

    task automatic testUpperBytes();
        word_t u1;
        word_t u2;
        int    base;
        startTest();
        for (int t = 0; t < NUM_THREADS; t++) begin
            u1 = $urandom & 32'h000f_ffff;
            u2 = $urandom & 32'h000f_ffff;
            base = 12'h500 + 32 * t;
            prog[t][0] = encU(u1, 1, OP_LUI);
            prog[t][1] = encU(u2, 2, OP_AUIPC);        // At pc 4
            prog[t][2] = encI(123, 0, 0, 0, OP_OPIMM); // Write to x0
            prog[t][3] = encS(base, 1, 0, 2);
            prog[t][4] = encS(base + 4, 2, 0, 2);
            prog[t][5] = encS(base + 8, 0, 0, 2);
            prog[t][6] = encS(base + 12, 1, 0, 0);     // SB
            prog[t][7] = encS(base + 16, 2, 0, 1);     // SH
            prog[t][8] = SPIN;
            expectStore(t, base, u1 << 12, 4'b1111);
            expectStore(t, base + 4, 32'd4 + (u2 << 12), 4'b1111);
            expectStore(t, base + 8, '0, 4'b1111);
            expectStore(t, base + 12, u1 << 12, 4'b0001);
            expectStore(t, base + 16, 32'd4 + (u2 << 12), 4'b0011);
        end
        compareStores();
    endtask

    initial begin
        QClk = 1'b0;
        reset = 1'b1;
        InstFetchQ101H = NOP;
        MemRdDataQ104H = '0;
        nextInstr = NOP;
        nextLoad = '0;
        quietCheck = 1'b0;
        cyc = 0;
        void'($urandom(32'h8068_d4f4));
        testResetOrder();
        testAlu();
        testIsolation();
        testControl();
        testUpperBytes();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== rtl/barrelCore.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// Four-thread barrel core, five stages Q100 to Q104
// Imem must return the instruction one cycle after the PC
// Dmem must answer loads in exactly one cycle, no stalls
////////////////////////////////////////////////////////////
module barrelCore (
    input  logic                QClk,
    input  logic                reset,
    output barrelPkg::word_t    PcQ100H,
    input  barrelPkg::instr_t   InstFetchQ101H,  // Registered inside imem
    output barrelPkg::dmemReq_t Dmem,
    input  barrelPkg::word_t    MemRdDataQ104H
);
    import barrelPkg::*;

    fetchQ101_t fetchQ101;
    decQ102_t   decQ102;
    exeQ103_t   exeQ103;
    pcUpdate_t  pcUpdate;     // Q102 back to fetch
    regWrite_t  regWr;        // Q104 back to regfile
    regIdx_t    rdPtr1;
    regIdx_t    rdPtr2;
    threadOh_t  rdThread;
    word_t      rdData1;
    word_t      rdData2;

    threadFetch iFetch (
        .QClk      (QClk),
        .reset     (reset),
        .PcUpdate  (pcUpdate),
        .PcQ100H   (PcQ100H),
        .FetchQ101 (fetchQ101)
    );

    decodeStage iDecode (
        .QClk           (QClk),
        .reset          (reset),
        .FetchQ101      (fetchQ101),
        .InstFetchQ101H (InstFetchQ101H),
        .RdPtr1         (rdPtr1),
        .RdPtr2         (rdPtr2),
        .RdThread       (rdThread),
        .RdData1        (rdData1),
        .RdData2        (rdData2),
        .DecQ102        (decQ102)
    );

    regFile iRegs (
        .QClk     (QClk),
        .reset    (reset),
        .RdThread (rdThread),
        .RdPtr1   (rdPtr1),
        .RdPtr2   (rdPtr2),
        .RdData1  (rdData1),
        .RdData2  (rdData2),
        .Wr       (regWr)
    );

    executeStage iExecute (
        .QClk     (QClk),
        .reset    (reset),
        .DecQ102  (decQ102),
        .PcUpdate (pcUpdate),
        .ExeQ103  (exeQ103)
    );

    memWriteback iMemWb (
        .QClk           (QClk),
        .reset          (reset),
        .ExeQ103        (exeQ103),
        .Dmem           (Dmem),
        .MemRdDataQ104H (MemRdDataQ104H),
        .Wr             (regWr)
    );

endmodule

// ==== rtl/memWriteback.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// Data memory request in Q103, writeback in Q104
// Load data is sampled one cycle after the request
// Byte enables are low-aligned, the address is not used for lanes
////////////////////////////////////////////////////////////
module memWriteback (
    input  logic                 QClk,
    input  logic                 reset,
    input  barrelPkg::exeQ103_t  ExeQ103,
    output barrelPkg::dmemReq_t  Dmem,
    input  barrelPkg::word_t     MemRdDataQ104H,
    output barrelPkg::regWrite_t Wr
);
    import barrelPkg::*;

    exeQ103_t q104;
    byteEn_t  byteEn;
    word_t    wrData;

    // Size from funct3[1:0]
    always_comb begin
        unique case (ExeQ103.funct3[1:0])
            2'b00:   byteEn = 4'b0001;   // Byte
            2'b01:   byteEn = 4'b0011;   // Half
            2'b10:   byteEn = 4'b1111;   // Word
            default: byteEn = 4'b0000;   // Illegal size
        endcase
    end

    // Strobes only for a valid instruction
    assign Dmem = '{
        address   : ExeQ103.aluOut,
        writeData : ExeQ103.rs2Data,
        rd        : ExeQ103.valid && ExeQ103.ctrl.memRd,
        wr        : ExeQ103.valid && ExeQ103.ctrl.memWr,
        byteEn    : byteEn
    };

    // Q103 to Q104
    always_ff @(posedge QClk) begin
        if (reset) begin
            q104.valid <= 1'b0;
        end else begin
            q104 <= ExeQ103;
        end
    end

    // Writeback source
    always_comb begin
        if (q104.ctrl.memToReg) begin
            wrData = MemRdDataQ104H;
        end else if (q104.ctrl.pcToReg) begin
            wrData = q104.pcPlus4;     // Link
        end else begin
            wrData = q104.aluOut;
        end
    end

    assign Wr = '{en: q104.valid && q104.ctrl.regWr, thread: q104.thread, rd: q104.rd,
                  data: wrData};

    memSizeLegal: assert property (@(posedge QClk) disable iff (reset)
        (Dmem.rd || Dmem.wr) |-> ExeQ103.funct3[1:0] != 2'b11);

endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// Execute, stage Q102
// Next PC goes back to fetch in the same cycle
// JALR target is the raw adder result, bit 0 not cleared
////////////////////////////////////////////////////////////
module executeStage (
    input  logic                 QClk,
    input  logic                 reset,
    input  barrelPkg::decQ102_t  DecQ102,
    output barrelPkg::pcUpdate_t PcUpdate,
    output barrelPkg::exeQ103_t  ExeQ103
);
    import barrelPkg::*;

    instr_t  instr;
    ctrl_t   ctrl;
    opcode_t opcode;
    funct3_t funct3;
    word_t   immI;
    word_t   immS;
    word_t   immB;
    word_t   immU;
    word_t   immJ;
    aluOp_e  aluOp;
    word_t   aluIn1;
    word_t   aluIn2;
    word_t   aluOut;
    word_t   pcPlus4;
    word_t   nextPc;
    logic    branchTaken;

    assign instr  = DecQ102.instr;
    assign ctrl   = DecQ102.ctrl;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    //////////////////////////////////////////////////////////////
    // Immediates

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // ALU control, funct7[5] only for OP and the OP-IMM shifts
    always_comb begin
        if (ctrl.lui || ctrl.auiPc || ctrl.memRd || ctrl.store) begin
            aluOp = ALU_ADD;                              // Address or upper imm
        end else if (opcode == OP_OP || (opcode == OP_OPIMM && funct3[1:0] == 2'b01)) begin
            aluOp = aluOp_e'({instr[30], funct3});
        end else begin
            aluOp = aluOp_e'({1'b0, funct3});
        end
    end

    // Operand select
    always_comb begin
        aluIn1 = DecQ102.rs1Data;
        aluIn2 = DecQ102.rs2Data;                         // OP and branches
        if (ctrl.lui) begin
            aluIn1 = '0;
            aluIn2 = immU;
        end else if (ctrl.auiPc) begin
            aluIn1 = DecQ102.pc;
            aluIn2 = immU;
        end else if (ctrl.iTypeImm) begin
            aluIn2 = immI;
        end else if (ctrl.store) begin
            aluIn2 = immS;
        end
    end

    aluUnit iAlu (
        .Op  (aluOp),
        .In1 (aluIn1),
        .In2 (aluIn2),
        .Out (aluOut)
    );

    //////////////////////////////////////////////////////////////
    // Branch compare and next PC

    always_comb begin
        unique case (funct3)
            3'b000:  branchTaken = (aluIn1 == aluIn2);                    // BEQ
            3'b001:  branchTaken = (aluIn1 != aluIn2);                    // BNE
            3'b100:  branchTaken = ($signed(aluIn1) < $signed(aluIn2));   // BLT
            3'b101:  branchTaken = ($signed(aluIn1) >= $signed(aluIn2));  // BGE
            3'b110:  branchTaken = (aluIn1 < aluIn2);                     // BLTU
            3'b111:  branchTaken = (aluIn1 >= aluIn2);                    // BGEU
            default: branchTaken = 1'b0;
        endcase
    end

    assign pcPlus4 = DecQ102.pc + PC_STEP;

    always_comb begin
        if (ctrl.jalr) begin
            nextPc = aluOut;                              // rs1 + immI
        end else if (ctrl.jal) begin
            nextPc = DecQ102.pc + immJ;
        end else if (ctrl.branch && branchTaken) begin
            nextPc = DecQ102.pc + immB;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign PcUpdate = '{valid: DecQ102.valid, thread: DecQ102.thread, nextPc: nextPc};

    // Q102 to Q103
    always_ff @(posedge QClk) begin
        if (reset) begin
            ExeQ103.valid <= 1'b0;
        end else begin
            ExeQ103 <= '{
                valid   : DecQ102.valid,
                thread  : DecQ102.thread,
                pcPlus4 : pcPlus4,
                aluOut  : aluOut,
                rs2Data : DecQ102.rs2Data,
                funct3  : funct3,
                rd      : instr[10:7],                    // Low 4 bits of rd
                ctrl    : ctrl
            };
        end
    end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// Four private banks of 16 registers
// Reads are combinational, writes land at the Q104 edge
// x0 is never written so it always reads zero
////////////////////////////////////////////////////////////
module regFile (
    input  logic                 QClk,
    input  logic                 reset,
    input  barrelPkg::threadOh_t RdThread,
    input  barrelPkg::regIdx_t   RdPtr1,
    input  barrelPkg::regIdx_t   RdPtr2,
    output barrelPkg::word_t     RdData1,
    output barrelPkg::word_t     RdData2,
    input  barrelPkg::regWrite_t Wr
);
    import barrelPkg::*;

    word_t banks [NUM_THREADS][NUM_REGS];

    // Write port, one thread bank at a time
    always_ff @(posedge QClk) begin
        for (int t = 0; t < NUM_THREADS; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (reset) begin
                    banks[t][r] <= '0;
                end else if (Wr.en && Wr.thread[t] && Wr.rd == regIdx_t'(r) && r != 0) begin
                    banks[t][r] <= Wr.data;
                end
            end
        end
    end

    // Read ports, OR of the selected bank
    always_comb begin
        RdData1 = '0;
        RdData2 = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (RdThread[t]) begin
                RdData1 |= banks[t][RdPtr1];
                RdData2 |= banks[t][RdPtr2];
            end
        end
    end

    // Writeback thread must come from a clean ring
    wrThreadOneHot: assert property (@(posedge QClk) disable iff (reset)
        Wr.en |-> $onehot(Wr.thread));

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// Decode, stage Q101
// Register pointers keep only the low 4 bits of rs1 and rs2
// Unknown opcodes decode as register writes, as in the ISA table
////////////////////////////////////////////////////////////
module decodeStage (
    input  logic                  QClk,
    input  logic                  reset,
    input  barrelPkg::fetchQ101_t FetchQ101,
    input  barrelPkg::instr_t     InstFetchQ101H,
    output barrelPkg::regIdx_t    RdPtr1,
    output barrelPkg::regIdx_t    RdPtr2,
    output barrelPkg::threadOh_t  RdThread,
    input  barrelPkg::word_t      RdData1,
    input  barrelPkg::word_t      RdData2,
    output barrelPkg::decQ102_t   DecQ102
);
    import barrelPkg::*;

    opcode_t opcode;
    ctrl_t   ctrlQ101;

    assign opcode   = InstFetchQ101H[6:0];
    assign RdPtr1   = InstFetchQ101H[18:15];   // rs1
    assign RdPtr2   = InstFetchQ101H[23:20];   // rs2
    assign RdThread = FetchQ101.thread;        // Combinational read, same cycle

    //////////////////////////////////////////////////////////////
    // Opcode decode

    always_comb begin
        ctrlQ101.jal      = (opcode == OP_JAL);
        ctrlQ101.jalr     = (opcode == OP_JALR);
        ctrlQ101.branch   = (opcode == OP_BRANCH);
        ctrlQ101.iTypeImm = (opcode == OP_OPIMM) || (opcode == OP_LOAD) || (opcode == OP_JALR);
        ctrlQ101.store    = (opcode == OP_STORE);
        ctrlQ101.lui      = (opcode == OP_LUI);
        ctrlQ101.auiPc    = (opcode == OP_AUIPC);
        ctrlQ101.regWr    = !((opcode == OP_STORE) || (opcode == OP_BRANCH));
        ctrlQ101.memRd    = (opcode == OP_LOAD);
        ctrlQ101.memWr    = (opcode == OP_STORE);
        ctrlQ101.memToReg = (opcode == OP_LOAD);
        ctrlQ101.pcToReg  = (opcode == OP_JAL) || (opcode == OP_JALR);
    end

    //////////////////////////////////////////////////////////////
    // Q101 to Q102

    always_ff @(posedge QClk) begin
        if (reset) begin
            DecQ102.valid <= 1'b0;
        end else begin
            DecQ102 <= '{
                valid   : FetchQ101.valid,
                thread  : FetchQ101.thread,
                pc      : FetchQ101.pc,
                instr   : InstFetchQ101H,
                rs1Data : RdData1,
                rs2Data : RdData2,
                ctrl    : ctrlQ101
            };
        end
    end

endmodule

// ==== rtl/threadFetch.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// Thread ring and per-thread PCs, stage Q100
// Fixed round robin 0,1,2,3 with every thread always enabled
////////////////////////////////////////////////////////////
module threadFetch (
    input  logic                  QClk,
    input  logic                  reset,
    input  barrelPkg::pcUpdate_t  PcUpdate,
    output barrelPkg::word_t      PcQ100H,
    output barrelPkg::fetchQ101_t FetchQ101
);
    import barrelPkg::*;

    threadOh_t threadQ100;              // One-hot token
    word_t     pcRegs [NUM_THREADS];

    // Token rotates left, thread 0 is first out of reset
    always_ff @(posedge QClk) begin
        if (reset) begin
            threadQ100 <= threadOh_t'(1);
        end else begin
            threadQ100 <= {threadQ100[NUM_THREADS-2:0], threadQ100[NUM_THREADS-1]};
        end
    end

    // Each PC loads only from its own thread's Q102 result
    always_ff @(posedge QClk) begin
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (reset) begin
                pcRegs[t] <= RESET_PC;
            end else if (PcUpdate.valid && PcUpdate.thread[t]) begin
                pcRegs[t] <= PcUpdate.nextPc;
            end
        end
    end

    // One-hot PC mux
    always_comb begin
        PcQ100H = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (threadQ100[t]) PcQ100H |= pcRegs[t];
        end
    end

    // Q100 to Q101, imem registers the instruction itself
    always_ff @(posedge QClk) begin
        if (reset) begin
            FetchQ101.valid <= 1'b0;
        end else begin
            FetchQ101 <= '{valid: 1'b1, thread: threadQ100, pc: PcQ100H};
        end
    end

    ringOneHot: assert property (@(posedge QClk) disable iff (reset) $onehot(threadQ100));

    // Update from Q102 belongs to the thread fetched two cycles back
    pcUpdOwner: assert property (@(posedge QClk) disable iff (reset)
        PcUpdate.valid |-> PcUpdate.thread == $past(threadQ100, 2));

endmodule

// ==== rtl/aluUnit.sv ====
`timescale 1ns/100ps
////////////////////////////////////////////////////////////
// RV32I integer ALU, purely combinational
// Codes outside the ten named ops return zero
////////////////////////////////////////////////////////////
module aluUnit (
    input  barrelPkg::aluOp_e Op,
    input  barrelPkg::word_t  In1,
    input  barrelPkg::word_t  In2,
    output barrelPkg::word_t  Out
);
    import barrelPkg::*;

    logic [4:0] shamt;

    assign shamt = In2[4:0];     // Only low 5 bits shift

    always_comb begin
        unique case (Op)
            // Adder
            ALU_ADD:  Out = In1 + In2;
            ALU_SUB:  Out = In1 - In2;
            ALU_SLT:  Out = word_t'($signed(In1) < $signed(In2));
            ALU_SLTU: Out = word_t'(In1 < In2);
            // Shifter
            ALU_SLL:  Out = In1 << shamt;
            ALU_SRL:  Out = In1 >> shamt;
            ALU_SRA:  Out = $signed(In1) >>> shamt;
            // Bitwise
            ALU_XOR:  Out = In1 ^ In2;
            ALU_OR:   Out = In1 | In2;
            ALU_AND:  Out = In1 & In2;
            default:  Out = '0;
        endcase
    end

endmodule

// ==== rtl/barrelPkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, types and stage records of the barrel core
// RV32I subset with 16 registers per thread (RV32E style)
// Loads return the raw bus word with no sign or zero extension
////////////////////////////////////////////////////////////
package barrelPkg;

    // Core dimensions
    localparam int XLEN        = 32;
    localparam int NUM_THREADS = 4;
    localparam int NUM_REGS    = 16;

    typedef logic [XLEN-1:0]        word_t;
    typedef logic [31:0]            instr_t;
    typedef logic [3:0]             regIdx_t;   // Low 4 bits of rs/rd
    typedef logic [NUM_THREADS-1:0] threadOh_t;
    typedef logic [3:0]             byteEn_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [6:0]             opcode_t;

    localparam word_t PC_STEP  = 32'd4;
    localparam word_t RESET_PC = 32'd0;

    // Major opcodes
    localparam opcode_t OP_OP     = 7'b0110011;
    localparam opcode_t OP_OPIMM  = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } aluOp_e;

    //////////////////////////////////////////////////////////////
    // Stage records

    typedef struct packed {
        logic jal;
        logic jalr;
        logic branch;
        logic iTypeImm;     // OP-IMM, LOAD, JALR
        logic store;
        logic lui;
        logic auiPc;
        logic regWr;
        logic memRd;
        logic memWr;
        logic memToReg;
        logic pcToReg;      // JAL/JALR link
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        threadOh_t thread;
        word_t     pc;
    } fetchQ101_t;

    typedef struct packed {
        logic      valid;
        threadOh_t thread;
        word_t     pc;
        instr_t    instr;
        word_t     rs1Data;
        word_t     rs2Data;
        ctrl_t     ctrl;
    } decQ102_t;

    typedef struct packed {
        logic      valid;
        threadOh_t thread;
        word_t     pcPlus4;
        word_t     aluOut;
        word_t     rs2Data;
        funct3_t   funct3;
        regIdx_t   rd;
        ctrl_t     ctrl;
    } exeQ103_t;

    typedef struct packed {
        logic      valid;
        threadOh_t thread;
        word_t     nextPc;
    } pcUpdate_t;

    typedef struct packed {
        logic      en;
        threadOh_t thread;
        regIdx_t   rd;
        word_t     data;
    } regWrite_t;

    typedef struct packed {
        word_t   address;
        word_t   writeData;
        logic    rd;
        logic    wr;
        byteEn_t byteEn;
    } dmemReq_t;

endpackage
